/* bus_cycle_fsm.sv */
// 68000 bus-cycle FSM for the dtack handshake, the interrupt acknowledge and the vblank irq
`timescale 1ns/10ps

module bus_cycle_fsm import mapper_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cpu_asn,
    input  logic [1:0] cpu_dsn,
    input  logic [2:0] cpu_fc,
    input  logic       bus_cs,
    input  logic       bus_busy,
    input  logic       vint,
    // mode of the region hit by the current address
    input  wait_mode_t wait_mode,
    wait_if.fsm        w,
    output logic       cpu_dtackn,
    output logic [2:0] cpu_ipln,
    output logic       cpu_vpan,
    output logic [1:0] mcu_intn
);

    cycle_state_t state;
    cycle_state_t state_nx;
    // wait mode held for the whole cycle
    wait_mode_t   cyc_mode;
    logic         bus_active;
    logic         inta;
    logic         stall;
    logic         last_vint;
    logic         irq_req;

    // address strobe with either data strobe
    assign bus_active = ~cpu_asn & ~&cpu_dsn;
    // function code 7 marks interrupt acknowledge
    assign inta       = ~cpu_asn & (&cpu_fc);
    // selected device not ready yet
    assign stall      = bus_cs & bus_busy;

    always_comb begin
        state_nx = state;
        case (state)
            IDLE: begin
                if (inta) begin
                    state_nx = INTACK;
                end else if (bus_active) begin
                    state_nx = COUNT;
                end
            end
            COUNT: begin
                // aborted cycle falls straight back
                if (cpu_asn) begin
                    state_nx = IDLE;
                end else if (w.wait_done && !stall) begin
                    state_nx = ACK;
                end
            end
            ACK, INTACK: begin
                if (cpu_asn) begin
                    state_nx = IDLE;
                end
            end
            default: state_nx = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            cyc_mode  <= WAIT1;
            last_vint <= 1'b0;
            irq_req   <= 1'b0;
        end else begin
            state     <= state_nx;
            last_vint <= vint;
            // capture mode as the cycle starts
            if (state == IDLE && state_nx == COUNT) begin
                cyc_mode <= wait_mode;
            end
            // ack clears before a new edge can set
            if (inta) begin
                irq_req <= 1'b0;
            end else if (vint && !last_vint) begin
                irq_req <= 1'b1;
            end
        end
    end

    // counter kept clear between cycles
    assign w.wait_clr  = state == IDLE;
    assign w.wait_mode = cyc_mode;

    // released as soon as asn rises
    assign cpu_dtackn = (state != ACK) | cpu_asn;
    // autovector during the acknowledge cycle
    assign cpu_vpan   = state != INTACK;
    // level 4 request
    assign cpu_ipln   = irq_req ? 3'b011 : 3'b111;
    assign mcu_intn   = {1'b1, ~irq_req};

endmodule

/* mapper_config.svh */
// mapper sizing and register map constants, included by the package, interfaces and RTL
`ifndef MAPPER_CONFIG_SVH
`define MAPPER_CONFIG_SVH

// register file depth in bytes
`define MAP_NUM_REGS 32

// address windows decoded in priority order
`define MAP_NUM_REGIONS 8

// sound cpu latch register
`define MAP_SND_REG 3

// first window register
// control byte at base + 2r, base byte at base + 2r + 1
`define MAP_CTRL_BASE 16

// cpu clock enable rate as num/den of clk
`define MAP_CEN_NUM 29
`define MAP_CEN_DEN 146

`endif

/* mapper_ifs.sv */
// interfaces between the mapper blocks, window config from the regs and the wait handshake
`timescale 1ns/10ps
`include "mapper_config.svh"

// window settings decoded out of the register file
interface region_cfg_if import mapper_pkg::*; ();
    // base byte per region
    logic [7:0] base      [`MAP_NUM_REGIONS];
    // window size per region
    size_code_t size      [`MAP_NUM_REGIONS];
    // dtack wait mode per region
    wait_mode_t wait_mode [`MAP_NUM_REGIONS];
    // some region hit, returned from the decoder
    logic       any_active;

    modport regs (
        output base,
        output size,
        output wait_mode,
        input  any_active
    );

    modport decoder (
        input  base,
        input  size,
        input  wait_mode,
        output any_active
    );
endinterface

// clock enables and wait tick counting between timer and bus FSM
interface wait_if import mapper_pkg::*; ();
    logic       cen;
    logic       cenb;
    // held high between bus cycles
    logic       wait_clr;
    wait_mode_t wait_mode;
    logic       wait_done;

    modport timer (
        output cen,
        output cenb,
        output wait_done,
        input  wait_clr,
        input  wait_mode
    );

    modport fsm (
        input  wait_done,
        output wait_clr,
        output wait_mode
    );
endinterface

/* mapper_pkg.sv */
// shared mapper types for region selects, window sizes, dtack wait modes and bus-cycle states
`include "mapper_config.svh"

package mapper_pkg;

    // one bit per region, at most one set after priority
    typedef logic [`MAP_NUM_REGIONS-1:0] region_t;

    // window size from control bits 1:0
    // 8, 7, 5 or 3 high address bits compared against the base
    typedef enum logic [1:0] {
        SIZE_64K  = 2'd0,
        SIZE_128K = 2'd1,
        SIZE_512K = 2'd2,
        SIZE_2M   = 2'd3
    } size_code_t;

    // dtack timing from control bits 3:2
    // count modes ack on the 1st, 2nd or 3rd cen of the cycle
    typedef enum logic [1:0] {
        WAIT1    = 2'd0,
        WAIT2    = 2'd1,
        WAIT3    = 2'd2,
        WAIT_EXT = 2'd3
    } wait_mode_t;

    // 68000 bus cycle handshake
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        COUNT  = 2'd1,
        ACK    = 2'd2,
        INTACK = 2'd3
    } cycle_state_t;

endpackage

/* mapper_regs.sv */
// mapper register file, written by the cpu or the mcu, feeds the windows, sound latch and status port
`timescale 1ns/10ps
`include "mapper_config.svh"

module mapper_regs import mapper_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    // cpu side, register index from addr 5:1
    input  logic [4:0] cpu_addr,
    input  logic [7:0] cpu_data,
    input  logic       cpu_wr,
    // mcu side
    input  logic [4:0] mcu_addr,
    input  logic [7:0] mcu_data,
    input  logic       mcu_wr,
    // sound cpu latch
    input  logic       sndmap_rd,
    output logic [7:0] sndmap_dout,
    output logic       sndmap_obf,
    // status readback
    input  logic [7:0] st_addr,
    output logic [7:0] st_dout,
    region_cfg_if.regs cfg
);

    logic [7:0] mmr [`MAP_NUM_REGS];
    // cpu owns the registers until the mcu first writes
    logic       cpu_sel;
    logic       use_mcu;
    logic [4:0] wr_addr;
    logic [7:0] wr_data;
    logic       wr_en;
    logic [4:0] st_idx;

    // an mcu strobe always wins, so its first write lands too
    assign use_mcu = mcu_wr | ~cpu_sel;
    assign wr_addr = use_mcu ? mcu_addr : cpu_addr;
    assign wr_data = use_mcu ? mcu_data : cpu_data;
    // cpu writes only outside any mapped window
    assign wr_en   = use_mcu ? mcu_wr : (cpu_wr & ~cfg.any_active);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `MAP_NUM_REGS; i++) begin
                mmr[i] <= 8'd0;
            end
            cpu_sel    <= 1'b1;
            sndmap_obf <= 1'b0;
        end else begin
            // lock stays until reset
            if (mcu_wr) begin
                cpu_sel <= 1'b0;
            end
            if (wr_en) begin
                mmr[wr_addr] <= wr_data;
                // buffer full on latch write
                if (wr_addr == 5'(`MAP_SND_REG)) begin
                    sndmap_obf <= 1'b1;
                end
            end
            // sound read empties the latch
            if (sndmap_rd) begin
                sndmap_obf <= 1'b0;
            end
        end
    end

    assign sndmap_dout = mmr[`MAP_SND_REG];

    // status index
    // st_addr 2:0 picks the region, bit 3 picks base over control
    assign st_idx = 5'(`MAP_CTRL_BASE) + {1'b0, st_addr[2:0], st_addr[3]};

    always_ff @(posedge clk) begin
        st_dout <= mmr[st_idx];
    end

    // unpack window registers
    always_comb begin
        for (int r = 0; r < `MAP_NUM_REGIONS; r++) begin
            // control byte bits 1:0 size, 3:2 wait mode
            cfg.size[r]      = size_code_t'(mmr[`MAP_CTRL_BASE + 2 * r][1:0]);
            cfg.wait_mode[r] = wait_mode_t'(mmr[`MAP_CTRL_BASE + 2 * r][3:2]);
            cfg.base[r]      = mmr[`MAP_CTRL_BASE + 2 * r + 1];
        end
    end

endmodule

/* mapper_top.sv */
// memory mapper top level, wires the register file, decoder, wait timer and bus FSM
`timescale 1ns/10ps

module mapper_top import mapper_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    // cpu clock enables
    output logic        cpu_cen,
    output logic        cpu_cenb,
    // device handshake
    input  logic        bus_cs,
    input  logic        bus_busy,
    input  logic        edack,
    input  logic        vint,
    // 68000 bus
    input  logic [23:1] addr,
    input  logic [15:0] cpu_dout,
    input  logic [1:0]  cpu_dswn,
    input  logic [1:0]  cpu_dsn,
    input  logic        cpu_asn,
    input  logic [2:0]  cpu_fc,
    output logic        cpu_dtackn,
    output logic [2:0]  cpu_ipln,
    output logic        cpu_vpan,
    // sound cpu latch
    input  logic        sndmap_rd,
    output logic [7:0]  sndmap_dout,
    output logic        sndmap_obf,
    // mcu port
    input  logic [4:0]  mcu_addr,
    input  logic [7:0]  mcu_dout,
    input  logic        mcu_wr,
    output logic [1:0]  mcu_intn,
    // region chip selects
    output region_t     active,
    // status readback
    input  logic [7:0]  st_addr,
    output logic [7:0]  st_dout
);

    region_cfg_if cfg_bus ();
    wait_if       wait_bus ();
    wait_mode_t   dec_wait_mode;

    // low data byte, written while asn and lower write strobe are low
    mapper_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .cpu_addr    (addr[5:1]),
        .cpu_data    (cpu_dout[7:0]),
        .cpu_wr      (~cpu_asn & ~cpu_dswn[0]),
        .mcu_addr    (mcu_addr),
        .mcu_data    (mcu_dout),
        .mcu_wr      (mcu_wr),
        .sndmap_rd   (sndmap_rd),
        .sndmap_dout (sndmap_dout),
        .sndmap_obf  (sndmap_obf),
        .st_addr     (st_addr),
        .st_dout     (st_dout),
        .cfg         (cfg_bus.regs)
    );

    region_decoder u_decoder (
        .addr      (addr),
        .cpu_fc    (cpu_fc),
        .cfg       (cfg_bus.decoder),
        .active    (active),
        .wait_mode (dec_wait_mode)
    );

    wait_timer u_timer (
        .clk   (clk),
        .rst   (rst),
        .w     (wait_bus.timer),
        .edack (edack)
    );

    bus_cycle_fsm u_fsm (
        .clk        (clk),
        .rst        (rst),
        .cpu_asn    (cpu_asn),
        .cpu_dsn    (cpu_dsn),
        .cpu_fc     (cpu_fc),
        .bus_cs     (bus_cs),
        .bus_busy   (bus_busy),
        .vint       (vint),
        .wait_mode  (dec_wait_mode),
        .w          (wait_bus.fsm),
        .cpu_dtackn (cpu_dtackn),
        .cpu_ipln   (cpu_ipln),
        .cpu_vpan   (cpu_vpan),
        .mcu_intn   (mcu_intn)
    );

    assign cpu_cen  = wait_bus.cen;
    assign cpu_cenb = wait_bus.cenb;

endmodule

/* region_decoder.sv */
// combinational window match, lowest region wins, plus the dtack wait mode of the hit region
`timescale 1ns/10ps
`include "mapper_config.svh"

module region_decoder import mapper_pkg::*; (
    input  logic [23:1]   addr,
    input  logic [2:0]    cpu_fc,
    region_cfg_if.decoder cfg,
    output region_t       active,
    output wait_mode_t    wait_mode
);

    // raw hits before priority
    region_t match;

    // high address bits against the base, count set by the size
    function automatic logic win_hit(
        input logic [23:1] a,
        input logic [7:0]  base,
        input size_code_t  sz
    );
        case (sz)
            SIZE_64K:  win_hit = a[23:16] == base;
            SIZE_128K: win_hit = a[23:17] == base[7:1];
            SIZE_512K: win_hit = a[23:19] == base[7:3];
            SIZE_2M:   win_hit = a[23:21] == base[7:5];
            default:   win_hit = 1'b0;
        endcase
    endfunction

    always_comb begin
        for (int r = 0; r < `MAP_NUM_REGIONS; r++) begin
            match[r] = win_hit(addr, cfg.base[r], cfg.size[r]);
        end
    end

    // priority encode to one-hot
    always_comb begin : prio
        logic taken;
        taken  = 1'b0;
        active = '0;
        for (int r = 0; r < `MAP_NUM_REGIONS; r++) begin
            active[r] = match[r] & ~taken;
            taken     = taken | match[r];
        end
        // no region during interrupt acknowledge
        if (cpu_fc == 3'b111) begin
            active = '0;
        end
    end

    // single cycle ack when nothing is mapped
    always_comb begin
        wait_mode = WAIT1;
        for (int r = 0; r < `MAP_NUM_REGIONS; r++) begin
            if (active[r]) begin
                wait_mode = cfg.wait_mode[r];
            end
        end
    end

    assign cfg.any_active = |active;

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the mapper testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_mapper

# the run result is decided by the pass line in the output
output=$(./obj_dir/Vtb_mapper 2>&1) || true
echo "$output"

if grep -qx "sim passed" <<< "$output"; then
    exit 0
else
    exit 1
fi

/* sources.f */
+incdir+.
mapper_pkg.sv
mapper_ifs.sv
mapper_regs.sv
region_decoder.sv
wait_timer.sv
bus_cycle_fsm.sv
mapper_top.sv
tb_mapper.sv

/* tb_mapper.sv */
// testbench for the mapper top level, run through sources.f with decode, wait, lock, latch and irq tests
`timescale 1ns/10ps
`include "mapper_config.svh"

module tb_mapper;

    logic        clk;
    logic        rst;
    logic        cpu_cen;
    logic        cpu_cenb;
    logic        bus_cs;
    logic        bus_busy;
    logic        edack;
    logic        vint;
    logic [23:1] addr;
    logic [15:0] cpu_dout;
    logic [1:0]  cpu_dswn;
    logic [1:0]  cpu_dsn;
    logic        cpu_asn;
    logic [2:0]  cpu_fc;
    logic        cpu_dtackn;
    logic [2:0]  cpu_ipln;
    logic        cpu_vpan;
    logic        sndmap_rd;
    logic [7:0]  sndmap_dout;
    logic        sndmap_obf;
    logic [4:0]  mcu_addr;
    logic [7:0]  mcu_dout;
    logic        mcu_wr;
    logic [1:0]  mcu_intn;
    logic [7:0]  active;
    logic [7:0]  st_addr;
    logic [7:0]  st_dout;

    // expected register contents
    logic [7:0]  shadow [`MAP_NUM_REGS];
    // set by the first mcu write
    logic        locked;
    // compare process enable
    logic        decode_on;
    integer      seed;

    mapper_top u_mapper_top (
        .clk         (clk),
        .rst         (rst),
        .cpu_cen     (cpu_cen),
        .cpu_cenb    (cpu_cenb),
        .bus_cs      (bus_cs),
        .bus_busy    (bus_busy),
        .edack       (edack),
        .vint        (vint),
        .addr        (addr),
        .cpu_dout    (cpu_dout),
        .cpu_dswn    (cpu_dswn),
        .cpu_dsn     (cpu_dsn),
        .cpu_asn     (cpu_asn),
        .cpu_fc      (cpu_fc),
        .cpu_dtackn  (cpu_dtackn),
        .cpu_ipln    (cpu_ipln),
        .cpu_vpan    (cpu_vpan),
        .sndmap_rd   (sndmap_rd),
        .sndmap_dout (sndmap_dout),
        .sndmap_obf  (sndmap_obf),
        .mcu_addr    (mcu_addr),
        .mcu_dout    (mcu_dout),
        .mcu_wr      (mcu_wr),
        .mcu_intn    (mcu_intn),
        .active      (active),
        .st_addr     (st_addr),
        .st_dout     (st_dout)
    );

    always #5 clk = ~clk;

    // window hit for byte address ba in region r
    function automatic logic window_match(input logic [23:0] ba, input int r);
        logic [7:0] ctrl;
        logic [7:0] base;
        int         nb;
        ctrl = shadow[`MAP_CTRL_BASE + 2 * r];
        base = shadow[`MAP_CTRL_BASE + 2 * r + 1];
        // compared high bits per size code
        case (ctrl[1:0])
            2'd0:    nb = 8;
            2'd1:    nb = 7;
            2'd2:    nb = 5;
            default: nb = 3;
        endcase
        return ((ba[23:16] ^ base) >> (8 - nb)) == 8'd0;
    endfunction

    // lowest matching region as one-hot, none during int ack
    function automatic logic [7:0] model_region(input logic [23:0] ba, input logic [2:0] fc);
        logic [7:0] sel;
        sel = 8'd0;
        if (fc != 3'd7) begin
            // walk down so region 0 is applied last
            for (int r = 7; r >= 0; r--) begin
                if (window_match(ba, r)) begin
                    sel = 8'd1 << r;
                end
            end
        end
        return sel;
    endfunction

    // cen pulses until dtack for the winning region
    function automatic int model_wait(input logic [23:0] ba);
        int mode;
        mode = 0;
        for (int r = 7; r >= 0; r--) begin
            if (window_match(ba, r)) begin
                mode = int'(shadow[`MAP_CTRL_BASE + 2 * r][3:2]);
            end
        end
        return mode + 1;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            abort_run($sformatf("error %s: expected %0h actual %0h", name, exp, act));
        end
    endtask

    task automatic wait_dtack_low(input string what);
        int t;
        for (t = 0; t < 200 && cpu_dtackn; t++) begin
            @(negedge clk);
        end
        if (cpu_dtackn) begin
            abort_run($sformatf("no dtack seen during %s", what));
        end
    endtask

    // end the cycle, dtack must let go at once
    task automatic release_bus();
        @(posedge clk);
        cpu_asn  <= 1'b1;
        cpu_dsn  <= 2'b11;
        cpu_dswn <= 2'b11;
        cpu_fc   <= 3'd0;
        @(negedge clk);
        check("dtack release", 32'd1, 32'(cpu_dtackn));
    endtask

    // byte write through the low data lane, at an address above every window
    task automatic cpu_write(input logic [4:0] idx, input logic [7:0] data);
        logic [23:0] ba;
        ba = {8'hf0, 10'd0, idx, 1'b0};
        @(posedge clk);
        addr     <= ba[23:1];
        cpu_dout <= {8'h00, data};
        cpu_fc   <= 3'd5;
        cpu_asn  <= 1'b0;
        cpu_dsn  <= 2'b10;
        cpu_dswn <= 2'b10;
        @(negedge clk);
        // no window may claim the write
        check("unmapped write address", 32'd0, 32'(active));
        wait_dtack_low("cpu write");
        release_bus();
        if (!locked) begin
            shadow[idx] = data;
        end
    endtask

    task automatic mcu_write(input logic [4:0] idx, input logic [7:0] data);
        @(posedge clk);
        mcu_addr <= idx;
        mcu_dout <= data;
        mcu_wr   <= 1'b1;
        @(posedge clk);
        mcu_wr   <= 1'b0;
        shadow[idx] = data;
        locked      = 1'b1;
    endtask

    // status port, region in bits 2:0 and base select in bit 3
    task automatic read_back(input logic [4:0] idx);
        @(posedge clk);
        st_addr <= {4'd0, idx[0], idx[3:1]};
        @(posedge clk);
        @(negedge clk);
        check($sformatf("readback reg %0d", idx), 32'(shadow[idx]), 32'(st_dout));
    endtask

    task automatic check_cen_rate();
        int n;
        int nb;
        n  = 0;
        nb = 0;
        for (int i = 0; i < 730; i++) begin
            @(negedge clk);
            // the two enables never share a clk
            check("cen cenb overlap", 32'd0, 32'(cpu_cen & cpu_cenb));
            if (cpu_cen) begin
                // exactly one cenb between two cen pulses
                if (n > 0) begin
                    check("cenb per cen period", 32'd1, 32'(nb));
                end
                n++;
                nb = 0;
            end
            if (cpu_cenb) begin
                nb++;
            end
        end
        // 730 clk at 29/146 gives 145
        check("cen rate", 32'd1, 32'(n >= 144 && n <= 146));
    endtask

    task automatic program_and_read();
        logic [4:0] idx;
        logic [7:0] data;
        for (int i = 0; i < 40; i++) begin
            idx  = 5'd16 + 5'($random(seed) & 15);
            data = 8'($random(seed));
            // keep base bytes in the lower half
            if (idx[0]) begin
                data[7] = 1'b0;
            end
            cpu_write(idx, data);
        end
        for (int i = 16; i < 32; i++) begin
            read_back(5'(i));
        end
    endtask

    task automatic decode_test();
        logic [23:0] ba;
        int          r;
        for (int round = 0; round < 8; round++) begin
            for (int k = 0; k < 8; k++) begin
                cpu_write(5'(16 + 2 * k), 8'($random(seed)) & 8'h0f);
                cpu_write(5'(17 + 2 * k), 8'($random(seed)) & 8'h7f);
            end
            decode_on = 1'b1;
            for (int k = 0; k < 40; k++) begin
                r  = $random(seed) & 7;
                ba = 24'($random(seed));
                // half of the addresses aimed at a window
                if ($random(seed) & 1) begin
                    ba[23:16] = shadow[17 + 2 * r];
                end
                @(posedge clk);
                addr   <= ba[23:1];
                cpu_fc <= 3'($random(seed));
            end
            @(negedge clk);
            decode_on = 1'b0;
        end
    endtask

    // cen pulses from the first edge with strobes low to the dtack fall
    task automatic count_wait_cens(input logic [23:0] ba, output int n);
        logic done;
        n    = 0;
        done = 1'b0;
        @(posedge clk);
        addr    <= ba[23:1];
        cpu_fc  <= 3'd5;
        cpu_asn <= 1'b0;
        cpu_dsn <= 2'b00;
        @(posedge clk);
        for (int t = 0; t < 200 && !done; t++) begin
            @(negedge clk);
            if (!cpu_dtackn) begin
                done = 1'b1;
            end else if (cpu_cen) begin
                n++;
            end
        end
        if (!done) begin
            abort_run("no dtack seen during wait cycle");
        end
        release_bus();
    endtask

    task automatic wait_test();
        logic [23:0] ba;
        int          n;
        ba = 24'h10_2468;
        cpu_write(5'd17, 8'h10);
        for (int m = 0; m < 3; m++) begin
            cpu_write(5'd16, {4'h0, 2'(m), 2'b00});
            for (int rep = 0; rep < 4; rep++) begin
                count_wait_cens(ba, n);
                check($sformatf("wait mode %0d", m), 32'(model_wait(ba)), 32'(n));
            end
        end
        // external ack mode
        cpu_write(5'd16, 8'h0c);
        @(posedge clk);
        addr    <= ba[23:1];
        cpu_fc  <= 3'd5;
        cpu_asn <= 1'b0;
        cpu_dsn <= 2'b00;
        for (int t = 0; t < 40; t++) begin
            @(negedge clk);
            check("ext early ack", 32'd1, 32'(cpu_dtackn));
        end
        @(posedge clk);
        edack <= 1'b1;
        wait_dtack_low("external ack cycle");
        release_bus();
        @(posedge clk);
        edack <= 1'b0;
    endtask

    task automatic sound_test();
        logic [7:0] v;
        v = 8'($random(seed));
        cpu_write(5'(`MAP_SND_REG), v);
        @(negedge clk);
        check("sound data", 32'(shadow[`MAP_SND_REG]), 32'(sndmap_dout));
        check("sound flag set", 32'd1, 32'(sndmap_obf));
        @(posedge clk);
        sndmap_rd <= 1'b1;
        @(posedge clk);
        sndmap_rd <= 1'b0;
        @(negedge clk);
        check("sound flag clear", 32'd0, 32'(sndmap_obf));
    endtask

    task automatic lock_test();
        mcu_write(5'd20, 8'h5a);
        read_back(5'd20);
        // cpu write ignored from here on
        cpu_write(5'd20, 8'ha5);
        read_back(5'd20);
        mcu_write(5'd21, 8'h3c);
        read_back(5'd21);
    endtask

    task automatic irq_test();
        @(posedge clk);
        vint <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check("irq level", 32'(3'b011), 32'(cpu_ipln));
        check("mcu irq", 32'(2'b10), 32'(mcu_intn));
        @(posedge clk);
        vint    <= 1'b0;
        // interrupt acknowledge
        cpu_fc  <= 3'd7;
        cpu_asn <= 1'b0;
        cpu_dsn <= 2'b10;
        @(posedge clk);
        @(negedge clk);
        check("ack vpa", 32'd0, 32'(cpu_vpan));
        check("ack level", 32'(3'b111), 32'(cpu_ipln));
        check("ack mcu irq", 32'(2'b11), 32'(mcu_intn));
        release_bus();
        @(negedge clk);
        check("vpa release", 32'd1, 32'(cpu_vpan));
    endtask

    // decode compare, inputs change on posedge
    always @(negedge clk) begin
        if (decode_on) begin
            check("region decode", 32'(model_region({addr, 1'b0}, cpu_fc)), 32'(active));
        end
    end

    initial begin
        seed      = 95328;
        clk       = 1'b0;
        locked    = 1'b0;
        decode_on = 1'b0;
        for (int i = 0; i < `MAP_NUM_REGS; i++) begin
            shadow[i] = 8'd0;
        end
        rst       <= 1'b1;
        bus_cs    <= 1'b0;
        bus_busy  <= 1'b0;
        edack     <= 1'b0;
        vint      <= 1'b0;
        addr      <= '0;
        cpu_dout  <= 16'd0;
        cpu_dswn  <= 2'b11;
        cpu_dsn   <= 2'b11;
        cpu_asn   <= 1'b1;
        cpu_fc    <= 3'd0;
        sndmap_rd <= 1'b0;
        mcu_addr  <= 5'd0;
        mcu_dout  <= 8'd0;
        mcu_wr    <= 1'b0;
        st_addr   <= 8'd0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check("reset dtack", 32'd1, 32'(cpu_dtackn));
        check("reset ipl", 32'(3'b111), 32'(cpu_ipln));
        check("reset vpa", 32'd1, 32'(cpu_vpan));
        check("reset sound flag", 32'd0, 32'(sndmap_obf));
        check("reset mcu irq", 32'(2'b11), 32'(mcu_intn));
        check_cen_rate();
        program_and_read();
        decode_test();
        wait_test();
        sound_test();
        lock_test();
        irq_test();
        $display("sim passed");
        $finish;
    end

endmodule

/* wait_timer.sv */
// fractional cpu clock enable generator and per-cycle counter of wait ticks for dtack
`timescale 1ns/10ps
`include "mapper_config.svh"

module wait_timer import mapper_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    wait_if.timer w,
    // external acknowledge pin
    input  logic  edack
);

    localparam logic [7:0] CEN_NUM  = 8'(`MAP_CEN_NUM);
    localparam logic [7:0] CEN_DEN  = 8'(`MAP_CEN_DEN);
    // cenb fires when the phase passes this point
    localparam logic [7:0] CEN_HALF = CEN_DEN >> 1;

    // phase accumulator, always below den after update
    logic [7:0] acc;
    logic [7:0] sum;
    // cen pulses seen in this cycle, saturates at 3
    logic [1:0] cnt;
    logic       wrap;

    assign sum  = acc + CEN_NUM;
    assign wrap = sum >= CEN_DEN;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc    <= 8'd0;
            w.cen  <= 1'b0;
            w.cenb <= 1'b0;
        end else begin
            w.cen  <= wrap;
            // half crossing lands midway between cen pulses
            w.cenb <= (acc < CEN_HALF) && (sum >= CEN_HALF);
            acc    <= wrap ? sum - CEN_DEN : sum;
        end
    end

    // wait tick counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt         <= 2'd0;
            w.wait_done <= 1'b0;
        end else if (w.wait_clr) begin
            cnt         <= 2'd0;
            w.wait_done <= 1'b0;
        end else if (w.cen) begin
            if (cnt != 2'd3) begin
                cnt <= cnt + 2'd1;
            end
            if (w.wait_mode == WAIT_EXT) begin
                // edack sampled on each cen
                w.wait_done <= edack;
            end else if (cnt >= 2'(w.wait_mode)) begin
                // this cen is number cnt+1, mode code is target minus one
                w.wait_done <= 1'b1;
            end
        end
    end

endmodule
